/* logic/rv_isa_pkg.sv */
// ------------------------------
// RV32I encoding definitions for the ALU subset.
// Decode and the testbench reference model both read
// instruction words through inst_t.
// ------------------------------
package rv_isa_pkg;

  // data and address width
  localparam int xlen = 32;

  typedef logic [4:0] reg_index_t;
  typedef logic [6:0] opcode_t;
  typedef logic [2:0] funct3_t;
  typedef logic [6:0] funct7_t;

  // major opcodes of the kept operations
  localparam opcode_t op_reg = 7'b0110011;
  localparam opcode_t op_imm = 7'b0010011;

  // funct3 values, shared by the R and I forms
  localparam funct3_t f3_add_sub = 3'b000;
  localparam funct3_t f3_xor     = 3'b100;
  localparam funct3_t f3_or      = 3'b110;
  localparam funct3_t f3_and     = 3'b111;

  // funct7 selects between ADD and SUB, all others need zero
  localparam funct7_t funct7_base = 7'b0000000;
  localparam funct7_t funct7_sub  = 7'b0100000;

  typedef struct packed {
    funct7_t    funct7;
    reg_index_t rs2;
    reg_index_t rs1;
    funct3_t    funct3;
    reg_index_t rd;
    opcode_t    opcode;
  } r_type_t;

  typedef struct packed {
    logic [11:0] imm;
    reg_index_t  rs1;
    funct3_t     funct3;
    reg_index_t  rd;
    opcode_t     opcode;
  } i_type_t;

  // one instruction word, seen as either layout
  typedef union packed {
    r_type_t r;
    i_type_t i;
  } inst_t;

endpackage

/* logic/pipe_pkg.sv */
// ------------------------------
// Pipeline sizes and the records passed between stages:
// micro-op, four-slot group and retire record.
// ------------------------------
package pipe_pkg;

  // slots per fetch packet
  localparam int fetch_width  = 4;
  localparam int packet_bits  = fetch_width * rv_isa_pkg::xlen;
  // address step from one packet to the next
  localparam int packet_bytes = fetch_width * 4;

  typedef enum logic [2:0] {
    alu_add = 3'd0,
    alu_sub = 3'd1,
    alu_and = 3'd2,
    alu_or  = 3'd3,
    alu_xor = 3'd4
  } alu_op_t;

  // decoded instruction, imm already sign-extended
  typedef struct packed {
    logic                          valid;
    logic [rv_isa_pkg::xlen-1:0]   pc;
    alu_op_t                       op;
    rv_isa_pkg::reg_index_t        rd;
    rv_isa_pkg::reg_index_t        rs1;
    rv_isa_pkg::reg_index_t        rs2;
    logic                          use_imm;
    logic [rv_isa_pkg::xlen-1:0]   imm;
  } uop_t;

  // slot 0 holds the lowest pc
  typedef uop_t [fetch_width-1:0] group_t;

  // value is what went into rd, zero for x0
  typedef struct packed {
    logic                        valid;
    logic [rv_isa_pkg::xlen-1:0] pc;
    rv_isa_pkg::reg_index_t      rd;
    logic [rv_isa_pkg::xlen-1:0] value;
  } retire_t;

endpackage

/* logic/fetch_decode.sv */
// ------------------------------
// Fetch and decode stage. Walks the instruction memory one
// 16-byte packet at a time and registers one decoded group
// per accepted packet.
// ------------------------------
module fetch_decode #(
  parameter logic [31:0] reset_pc = 32'h0000_1000
) (
  input  logic                               clock,
  input  logic                               reset,
  input  logic [pipe_pkg::packet_bits-1:0]   icache_data,
  input  logic                               icache_valid,
  input  logic                               stall,
  output logic [rv_isa_pkg::xlen-1:0]        icache_addr,
  output pipe_pkg::group_t                   decoded
);

  logic             accept;
  pipe_pkg::group_t next_group;

  // turn one word into a micro-op, valid only for a kept operation
  function automatic pipe_pkg::uop_t decode_word(
    input rv_isa_pkg::inst_t         word,
    input logic [rv_isa_pkg::xlen-1:0] pc
  );
    pipe_pkg::uop_t uop;
    uop     = '0;
    uop.pc  = pc;
    case (word.r.opcode)
      rv_isa_pkg::op_reg: begin
        uop.rd  = word.r.rd;
        uop.rs1 = word.r.rs1;
        uop.rs2 = word.r.rs2;
        case (word.r.funct3)
          rv_isa_pkg::f3_add_sub: begin
            uop.op    = (word.r.funct7 == rv_isa_pkg::funct7_sub) ?
                        pipe_pkg::alu_sub : pipe_pkg::alu_add;
            uop.valid = (word.r.funct7 == rv_isa_pkg::funct7_base) ||
                        (word.r.funct7 == rv_isa_pkg::funct7_sub);
          end
          rv_isa_pkg::f3_xor: begin
            uop.op    = pipe_pkg::alu_xor;
            uop.valid = (word.r.funct7 == rv_isa_pkg::funct7_base);
          end
          rv_isa_pkg::f3_or: begin
            uop.op    = pipe_pkg::alu_or;
            uop.valid = (word.r.funct7 == rv_isa_pkg::funct7_base);
          end
          rv_isa_pkg::f3_and: begin
            uop.op    = pipe_pkg::alu_and;
            uop.valid = (word.r.funct7 == rv_isa_pkg::funct7_base);
          end
          default: uop.valid = 1'b0;
        endcase
      end
      rv_isa_pkg::op_imm: begin
        uop.rd      = word.i.rd;
        uop.rs1     = word.i.rs1;
        uop.use_imm = 1'b1;
        uop.imm     = {{20{word.i.imm[11]}}, word.i.imm};
        // no funct7 here, so every kept funct3 is valid
        case (word.i.funct3)
          rv_isa_pkg::f3_add_sub: uop.op = pipe_pkg::alu_add;
          rv_isa_pkg::f3_xor:     uop.op = pipe_pkg::alu_xor;
          rv_isa_pkg::f3_or:      uop.op = pipe_pkg::alu_or;
          rv_isa_pkg::f3_and:     uop.op = pipe_pkg::alu_and;
          default:                uop.op = pipe_pkg::alu_add;
        endcase
        uop.valid = (word.i.funct3 == rv_isa_pkg::f3_add_sub) ||
                    (word.i.funct3 == rv_isa_pkg::f3_xor) ||
                    (word.i.funct3 == rv_isa_pkg::f3_or) ||
                    (word.i.funct3 == rv_isa_pkg::f3_and);
      end
      default: uop.valid = 1'b0;
    endcase
    return uop;
  endfunction

  // a packet is taken when offered and the buffer is not stalling
  assign accept = icache_valid & ~stall;

  always_ff @(posedge clock) begin
    if (reset) begin
      icache_addr <= reset_pc;
    end else if (accept) begin
      icache_addr <= icache_addr + 32'(pipe_pkg::packet_bytes);
    end
  end

  always_comb begin
    for (int s = 0; s < pipe_pkg::fetch_width; s++) begin
      next_group[s]       = decode_word(icache_data[s*rv_isa_pkg::xlen +: rv_isa_pkg::xlen],
                                        icache_addr + 32'(4 * s));
      next_group[s].valid = next_group[s].valid & accept;
    end
  end

  // slot valid bits last a single cycle per packet
  always_ff @(posedge clock) begin
    if (reset) begin
      decoded <= '0;
    end else begin
      decoded <= next_group;
    end
  end

endmodule

/* logic/group_buffer.sv */
// ------------------------------
// Buffer between decode and execute. Catches the group
// already in flight when execute fills up, replays it
// once execute frees, and stalls fetch meanwhile.
// ------------------------------
module group_buffer (
  input  logic             clock,
  input  logic             reset,
  input  pipe_pkg::group_t decoded,
  input  logic             busy,
  output pipe_pkg::group_t issue,
  output logic             stall
);

  pipe_pkg::group_t held;
  logic             held_valid;
  logic             presenting;
  logic             consumer_full;

  // a group on issue this cycle will make execute busy next cycle
  always_comb begin
    presenting = 1'b0;
    for (int s = 0; s < pipe_pkg::fetch_width; s++) begin
      presenting = presenting | issue[s].valid;
    end
  end

  assign consumer_full = busy | presenting;
  assign stall         = held_valid | consumer_full;

  always_ff @(posedge clock) begin
    if (reset) begin
      issue      <= '0;
      held_valid <= 1'b0;
    end else if (consumer_full & ~held_valid) begin
      // execute just filled, keep the group that was on its way
      issue      <= '0;
      held       <= decoded;
      held_valid <= 1'b1;
    end else if (held_valid & ~consumer_full) begin
      // execute is free again, replay the held group
      issue      <= held;
      held_valid <= 1'b0;
    end else if (consumer_full) begin
      // still full and already holding, insert a bubble
      issue      <= '0;
    end else begin
      issue      <= decoded;
    end
  end

endmodule

/* logic/alu_execute.sv */
// ------------------------------
// Execute stage. Latches one group, runs its slots one
// per cycle against the architectural register file and
// reports each valid slot on the retire port.
// ------------------------------
module alu_execute (
  input  logic              clock,
  input  logic              reset,
  input  pipe_pkg::group_t  issue,
  output logic              busy,
  output pipe_pkg::retire_t retire
);

  localparam logic [1:0] last_slot = 2'(pipe_pkg::fetch_width - 1);

  logic                        active;
  logic [1:0]                  slot;
  pipe_pkg::group_t            cur;
  logic [rv_isa_pkg::xlen-1:0] regs [32];
  logic                        offered;
  logic                        accept;
  pipe_pkg::uop_t              uop;
  logic [rv_isa_pkg::xlen-1:0] src_a;
  logic [rv_isa_pkg::xlen-1:0] src_b;
  logic [rv_isa_pkg::xlen-1:0] result;

  always_comb begin
    offered = 1'b0;
    for (int s = 0; s < pipe_pkg::fetch_width; s++) begin
      offered = offered | issue[s].valid;
    end
  end

  // low during the last slot so a new group can follow
  assign busy   = active & (slot != last_slot);
  assign accept = offered & ~busy;

  assign uop   = cur[slot];
  // x0 always reads as zero
  assign src_a = (uop.rs1 == '0) ? '0 : regs[uop.rs1];
  assign src_b = uop.use_imm ? uop.imm : ((uop.rs2 == '0) ? '0 : regs[uop.rs2]);

  always_comb begin
    case (uop.op)
      pipe_pkg::alu_add: result = src_a + src_b;
      pipe_pkg::alu_sub: result = src_a - src_b;
      pipe_pkg::alu_and: result = src_a & src_b;
      pipe_pkg::alu_or:  result = src_a | src_b;
      pipe_pkg::alu_xor: result = src_a ^ src_b;
      default:           result = '0;
    endcase
  end

  always_ff @(posedge clock) begin
    if (accept) begin
      cur <= issue;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      active       <= 1'b0;
      slot         <= '0;
      retire.valid <= 1'b0;
      for (int r = 0; r < 32; r++) begin
        regs[r] <= '0;
      end
    end else begin
      if (active) begin
        retire.valid <= uop.valid;
        retire.pc    <= uop.pc;
        retire.rd    <= uop.rd;
        retire.value <= (uop.rd == '0) ? '0 : result;
        if (uop.valid && (uop.rd != '0)) begin
          regs[uop.rd] <= result;
        end
      end else begin
        retire.valid <= 1'b0;
      end

      // next group starts at slot 0, possibly right after slot 3
      if (accept) begin
        active <= 1'b1;
        slot   <= '0;
      end else if (active) begin
        slot <= slot + 2'd1;
        if (slot == last_slot) begin
          active <= 1'b0;
        end
      end
    end
  end

endmodule

/* logic/rv_alu_core.sv */
// ------------------------------
// Top level of the in-order ALU core: fetch and decode,
// group buffer and execute, fed by an instruction
// memory port and reporting retired instructions.
// ------------------------------
module rv_alu_core #(
  parameter logic [31:0] reset_pc = 32'h0000_1000
) (
  input  logic                             clock,
  input  logic                             reset,
  input  logic [pipe_pkg::packet_bits-1:0] icache_data,
  input  logic                             icache_valid,
  output logic [31:0]                      icache_addr,
  output pipe_pkg::retire_t                retire
);

  pipe_pkg::group_t decoded;
  pipe_pkg::group_t issue;
  logic             stall;
  logic             busy;

  fetch_decode #(
    .reset_pc     (reset_pc)
  ) fetch_decode_i (
    .clock        (clock),
    .reset        (reset),
    .icache_data  (icache_data),
    .icache_valid (icache_valid),
    .stall        (stall),
    .icache_addr  (icache_addr),
    .decoded      (decoded)
  );

  group_buffer group_buffer_i (
    .clock   (clock),
    .reset   (reset),
    .decoded (decoded),
    .busy    (busy),
    .issue   (issue),
    .stall   (stall)
  );

  alu_execute alu_execute_i (
    .clock  (clock),
    .reset  (reset),
    .issue  (issue),
    .busy   (busy),
    .retire (retire)
  );

endmodule

/* verification/rv_alu_core_props.sv */
// ------------------------------
// Concurrent checks on the fetch port and the retire
// stream, bound into every rv_alu_core instance.
// ------------------------------
module rv_alu_core_props (
  input logic              clock,
  input logic              reset,
  input logic              icache_valid,
  input logic              stall,
  input logic [31:0]       icache_addr,
  input pipe_pkg::retire_t retire
);
  timeunit 1ns;
  timeprecision 100ps;

  // number of failed assertions so far
  int unsigned failures = 0;
  logic [31:0] last_pc;
  logic        seen_retire;

  always_ff @(posedge clock) begin
    if (reset) begin
      seen_retire <= 1'b0;
      last_pc     <= '0;
    end else if (retire.valid) begin
      seen_retire <= 1'b1;
      last_pc     <= retire.pc;
    end
  end

  // an offered packet that was refused must not move the address
  addr_held_on_stall: assert property (@(posedge clock) disable iff (reset)
    (icache_valid && stall) |=> $stable(icache_addr))
    else begin
      failures++;
      $error("icache_addr moved although the offered packet was stalled");
    end

  no_retire_after_reset: assert property (@(posedge clock) reset |=> !retire.valid)
    else begin
      failures++;
      $error("retire.valid high in the cycle after reset");
    end

  // program order means pc only grows across retires
  retire_pc_increases: assert property (@(posedge clock) disable iff (reset)
    (retire.valid && seen_retire) |-> (retire.pc > last_pc))
    else begin
      failures++;
      $error("retire.pc did not increase over the previous retire");
    end

endmodule

bind rv_alu_core rv_alu_core_props props_i (
  .clock        (clock),
  .reset        (reset),
  .icache_valid (icache_valid),
  .stall        (stall),
  .icache_addr  (icache_addr),
  .retire       (retire)
);

/* verification/rv_alu_core_tb.sv */
// ------------------------------
// Testbench for rv_alu_core. Serves a fixed program from a
// table with random gaps, checks every retire against a
// register-file model and watches the fetch address.
// ------------------------------
module rv_alu_core_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int          num_packets = 12;
  localparam logic [31:0] start_pc    = 32'h0000_1000;
  // packets x slots x cycles per slot x period x margin
  localparam int          watchdog_ns = num_packets * 4 * 4 * 4 * 4;

  logic                             clock;
  logic                             reset;
  logic [pipe_pkg::packet_bits-1:0] icache_data;
  logic                             icache_valid;
  logic [31:0]                      icache_addr;
  pipe_pkg::retire_t                retire;

  // instruction memory, slot 0 first in each packet
  logic [31:0] prog [num_packets][4] = '{
    // immediates, negative values, dependent R-type
    '{32'h00500093, 32'hFFD00113, 32'h002081B3, 32'h40110233},
    '{32'h401002B3, 32'h0020C333, 32'h0020E3B3, 32'h00317433},
    '{32'hFFF0C493, 32'h0F016513, 32'h7FF27593, 32'h00708013},
    // x0 reads and unsupported encodings mixed in
    '{32'h00100633, 32'h022086B3, 32'h00209733, 32'h000017B7},
    '{32'h0030A813, 32'h80080813, 32'h005848B3, 32'h40208033},
    '{32'h00000000, 32'hFFFFFFFF, 32'h4020D0B3, 32'h0000006F},
    // back-to-back chains through the register file
    '{32'h12300A13, 32'h014A0A33, 32'h41418AB3, 32'h009AEB33},
    '{32'hFF0B7B93, 32'hFFF06C13, 32'h555C4C93, 32'h018C8D33},
    '{32'h419D0DB3, 32'h01BDCE33, 32'h001E0E93, 32'h0010DF13},
    '{32'h7FFE8F93, 32'h01FF8F33, 32'h41E080B3, 32'h0180F133},
    '{32'h0020C033, 32'h000061B3, 32'hFFF00213, 32'h004202B3},
    '{32'h40400333, 32'h0FF2F393, 32'h4020C433, 32'h1003E493}
  };

  logic [31:0]       model_regs [32];
  pipe_pkg::retire_t exp_q [$];
  logic [31:0]       rng = 32'h2e7f;
  logic [31:0]       prev_addr;
  logic              accepted_any = 1'b0;
  int                packets_taken = 0;
  int                mismatches = 0;
  int                other_errors = 0;

  rv_alu_core rv_alu_core_i (
    .clock        (clock),
    .reset        (reset),
    .icache_data  (icache_data),
    .icache_valid (icache_valid),
    .icache_addr  (icache_addr),
    .retire       (retire)
  );

  always #2 clock = ~clock;

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic report_mismatch(input string name, input logic [31:0] exp,
                                 input logic [31:0] got);
    mismatches++;
    $display("** Error at %0t ns: %s expected %h, got %h", $time, name, exp, got);
  endtask

  task automatic report_problem(input string what);
    other_errors++;
    $display("Error at %0t ns: %s", $time, what);
  endtask

  // walk the program in order and record what each kept slot must retire
  task automatic build_expected();
    rv_isa_pkg::inst_t w;
    logic [31:0]       a;
    logic [31:0]       b;
    logic [31:0]       v;
    logic              keep;
    pipe_pkg::retire_t rec;
    for (int r = 0; r < 32; r++) begin
      model_regs[r] = '0;
    end
    for (int p = 0; p < num_packets; p++) begin
      for (int s = 0; s < 4; s++) begin
        w    = prog[p][s];
        keep = 1'b1;
        v    = '0;
        a    = model_regs[w.r.rs1];
        if (w.r.opcode == rv_isa_pkg::op_reg) begin
          b = model_regs[w.r.rs2];
          case ({w.r.funct7, w.r.funct3})
            {rv_isa_pkg::funct7_base, rv_isa_pkg::f3_add_sub}: v = a + b;
            {rv_isa_pkg::funct7_sub, rv_isa_pkg::f3_add_sub}:  v = a - b;
            {rv_isa_pkg::funct7_base, rv_isa_pkg::f3_xor}:     v = a ^ b;
            {rv_isa_pkg::funct7_base, rv_isa_pkg::f3_or}:      v = a | b;
            {rv_isa_pkg::funct7_base, rv_isa_pkg::f3_and}:     v = a & b;
            default:                                           keep = 1'b0;
          endcase
        end else if (w.i.opcode == rv_isa_pkg::op_imm) begin
          b = 32'($signed(w.i.imm));
          case (w.i.funct3)
            rv_isa_pkg::f3_add_sub: v = a + b;
            rv_isa_pkg::f3_xor:     v = a ^ b;
            rv_isa_pkg::f3_or:      v = a | b;
            rv_isa_pkg::f3_and:     v = a & b;
            default:                keep = 1'b0;
          endcase
        end else begin
          keep = 1'b0;
        end
        if (keep) begin
          // x0 stays zero in the model too
          if (w.r.rd != '0) model_regs[w.r.rd] = v;
          else v = '0;
          rec = '{valid: 1'b1, pc: start_pc + 32'(16 * p + 4 * s), rd: w.r.rd, value: v};
          exp_q.push_back(rec);
        end
      end
    end
  endtask

  // outputs are stable at the falling edge
  task automatic check_outputs();
    pipe_pkg::retire_t exp;
    logic [31:0]       exp_addr;
    if (icache_addr != prev_addr) begin
      exp_addr = icache_valid ? prev_addr + 32'd16 : prev_addr;
      if (icache_addr != exp_addr) begin
        report_mismatch("icache_addr", exp_addr, icache_addr);
      end else begin
        packets_taken++;
        accepted_any = 1'b1;
      end
      prev_addr = icache_addr;
    end
    if (retire.valid) begin
      if (!accepted_any) begin
        report_problem("an instruction retired before any packet was fetched");
      end else if (exp_q.size() == 0) begin
        report_problem("an instruction retired after the whole program had retired");
      end else begin
        exp = exp_q.pop_front();
        if (retire.pc != exp.pc) report_mismatch("retire.pc", exp.pc, retire.pc);
        if (retire.rd != exp.rd) report_mismatch("retire.rd", 32'(exp.rd), 32'(retire.rd));
        if (retire.value != exp.value) report_mismatch("retire.value", exp.value, retire.value);
      end
    end
  endtask

  // present the packet at the current address, offered about three times in four
  task automatic drive_memory();
    logic [31:0] offset;
    int          idx;
    offset = icache_addr - start_pc;
    idx    = int'(offset >> 4);
    rng    = xorshift32(rng);
    if (offset < 32'(16 * num_packets)) begin
      icache_data  = {prog[idx][3], prog[idx][2], prog[idx][1], prog[idx][0]};
      icache_valid = (rng[1:0] != 2'b00);
    end else begin
      icache_data  = '0;
      icache_valid = 1'b0;
    end
  endtask

  task automatic step();
    check_outputs();
    drive_memory();
    @(negedge clock);
  endtask

  initial begin
    clock        = 1'b0;
    reset        = 1'b1;
    icache_data  = '0;
    icache_valid = 1'b0;
    prev_addr    = start_pc;
    build_expected();
    repeat (5) @(negedge clock);
    reset = 1'b0;
    if (icache_addr != start_pc) report_mismatch("icache_addr", start_pc, icache_addr);
    while (exp_q.size() != 0) begin
      step();
    end
    // a few idle cycles to catch extra retires
    repeat (8) step();
    if (packets_taken != num_packets) begin
      report_problem($sformatf("%0d packets were fetched instead of %0d",
                               packets_taken, num_packets));
    end
    $display("errors: %0d value mismatches, %0d other failures, %0d assertion failures",
             mismatches, other_errors, rv_alu_core_i.props_i.failures);
    if (mismatches == 0 && other_errors == 0 && rv_alu_core_i.props_i.failures == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  initial begin
    #(watchdog_ns);
    $display("watchdog expired: retirement stalled with %0d instructions still expected",
             exp_q.size());
    $display("TEST FAILED");
    $finish;
  end

endmodule

/* rv_alu_core.f */
logic/rv_isa_pkg.sv
logic/pipe_pkg.sv
logic/fetch_decode.sv
logic/group_buffer.sv
logic/alu_execute.sv
logic/rv_alu_core.sv
verification/rv_alu_core_props.sv
verification/rv_alu_core_tb.sv
